// File: hw/spmd_loader.sv
// host side program loader, the only wishbone master.
// on start it writes the image, kicks every tile, polls each tile in id
// order, reports its result as a print_stat pulse and finally reads the
// host cycle counter before pulsing loader_done_o
`timescale 1ns/1ps

module spmd_loader (
  input  logic                               clk_i,
  input  logic                               reset_i,
  input  logic                               start_i,
  input  logic [7:0]                         image_count_i,
  output logic [7:0]                         image_idx_o,
  input  spmd_pkg::spmd_epa_u                image_addr_i,
  input  logic [spmd_pkg::data_width-1:0]    image_data_i,
  output logic                               wb_cyc_o,
  output logic                               wb_stb_o,
  output logic                               wb_we_o,
  output spmd_pkg::spmd_epa_u                wb_adr_o,
  output logic [spmd_pkg::data_width-1:0]    wb_dat_o,
  output logic [spmd_pkg::data_width/8-1:0]  wb_sel_o,
  input  logic [spmd_pkg::data_width-1:0]    wb_dat_i,
  input  logic                               wb_ack_i,
  output logic                               print_stat_v_o,
  output logic [spmd_pkg::tile_id_width-1:0] print_stat_id_o,
  output logic [spmd_pkg::data_width-1:0]    print_stat_tag_o,
  output logic [spmd_pkg::data_width-1:0]    run_cycles_o,
  output logic                               loader_done_o
);
  import spmd_pkg::*;

  logic [2:0]               state_r;
  logic [7:0]               idx_r;
  logic [tile_id_width-1:0] tile_r;
  logic                     stb_r;
  logic                     we_r;
  logic                     pstat_r;
  logic                     done_r;
  spmd_epa_u                adr_r;
  logic [data_width-1:0]    dat_r;
  logic [tile_id_width-1:0] pstat_id_r;
  logic [data_width-1:0]    pstat_tag_r;
  logic [data_width-1:0]    run_cycles_r;
  spmd_epa_u                req_adr;
  logic                     req_we;
  logic [data_width-1:0]    req_dat;
  logic                     issue;
  logic                     resp;
  logic                     last_tile;

  function automatic spmd_epa_u tile_addr(input logic [tile_id_width-1:0] id,
                                          input logic [offset_width-1:0] off);
    spmd_epa_u a;
    a = '0;
    a.tile.tile_id = id;
    a.tile.offset  = off;
    return a;
  endfunction

  // next request, by state
  always_comb begin
    req_adr = tile_addr(tile_r, csr_status);
    req_we  = 1'b0;
    req_dat = '0;
    case (state_r)
      ld_load: begin
        req_adr = image_addr_i;
        req_we  = 1'b1;
        req_dat = image_data_i;
      end
      ld_start: begin
        req_adr = tile_addr(tile_r, csr_start);
        req_we  = 1'b1;
      end
      ld_result: req_adr = tile_addr(tile_r, csr_result);
      ld_cycle: begin
        req_adr             = '0;
        req_adr.host.host_sel = 1'b1;
        req_adr.host.csr_id   = host_csr_cycle;
      end
      default: ;
    endcase
  end

  // a new request only after stb has been low for a cycle
  assign issue     = (state_r != ld_idle) && !stb_r;
  assign resp      = stb_r && wb_ack_i;
  assign last_tile = tile_r == tile_id_width'(num_tiles - 1);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= ld_idle;
      stb_r   <= 1'b0;
      idx_r   <= '0;
      tile_r  <= '0;
      pstat_r <= 1'b0;
      done_r  <= 1'b0;
    end else begin
      pstat_r <= 1'b0;
      done_r  <= 1'b0;
      if (issue) begin
        stb_r <= 1'b1;
      end else if (resp) begin
        stb_r <= 1'b0;
      end
      case (state_r)
        ld_idle: begin
          if (start_i) begin
            idx_r   <= '0;
            tile_r  <= '0;
            state_r <= (image_count_i == '0) ? ld_start : ld_load;
          end
        end
        ld_load: begin
          if (resp) begin
            idx_r <= idx_r + 1'b1;
            if (idx_r == image_count_i - 8'd1) state_r <= ld_start;
          end
        end
        ld_start: begin
          if (resp) begin
            tile_r <= tile_r + 1'b1; // wraps back to tile 0 for polling
            if (last_tile) state_r <= ld_poll;
          end
        end
        ld_poll: begin
          if (resp && wb_dat_i[0]) state_r <= ld_result;
        end
        ld_result: begin
          if (resp) begin
            pstat_r <= 1'b1;
            tile_r  <= tile_r + 1'b1;
            state_r <= last_tile ? ld_cycle : ld_poll;
          end
        end
        ld_cycle: begin
          if (resp) begin
            done_r  <= 1'b1;
            state_r <= ld_idle;
          end
        end
        default: state_r <= ld_idle;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (issue) begin
      adr_r <= req_adr;
      we_r  <= req_we;
      dat_r <= req_dat;
    end
    if (resp && state_r == ld_result) begin
      pstat_id_r  <= tile_r;
      pstat_tag_r <= wb_dat_i;
    end
    if (resp && state_r == ld_cycle) begin
      run_cycles_r <= wb_dat_i;
    end
  end

  assign image_idx_o      = idx_r;
  assign wb_cyc_o         = stb_r; // single master, one beat per cycle
  assign wb_stb_o         = stb_r;
  assign wb_we_o          = we_r;
  assign wb_adr_o         = adr_r;
  assign wb_dat_o         = dat_r;
  assign wb_sel_o         = '1;
  assign print_stat_v_o   = pstat_r;
  assign print_stat_id_o  = pstat_id_r;
  assign print_stat_tag_o = pstat_tag_r;
  assign run_cycles_o     = run_cycles_r;
  assign loader_done_o    = done_r;

endmodule

// File: hw/spmd_manycore.sv
// top of the spmd subsystem: reset sequencer, host loader, router and four
// tiles. the outside feeds the program image through the lookup port and
// starts a run with start_i
`timescale 1ns/1ps

module spmd_manycore (
  input  logic                               clk_i,
  input  logic                               reset_i,
  input  logic                               start_i,
  input  logic [7:0]                         image_count_i,
  output logic [7:0]                         image_idx_o,
  input  spmd_pkg::spmd_epa_u                image_addr_i,
  input  logic [spmd_pkg::data_width-1:0]    image_data_i,
  output logic                               print_stat_v_o,
  output logic [spmd_pkg::tile_id_width-1:0] print_stat_id_o,
  output logic [spmd_pkg::data_width-1:0]    print_stat_tag_o,
  output logic [spmd_pkg::data_width-1:0]    run_cycles_o,
  output logic                               loader_done_o
);
  import spmd_pkg::*;

  logic                                 core_reset;
  logic                                 scrub_v;
  logic [offset_width-1:0]              scrub_addr;
  logic                                 wb_cyc;
  logic                                 wb_stb;
  logic                                 wb_we;
  logic                                 wb_ack;
  spmd_epa_u                            wb_adr;
  logic [data_width-1:0]                wb_dat_w;
  logic [data_width-1:0]                wb_dat_r;
  logic [num_tiles-1:0]                 tile_stb;
  logic [num_tiles-1:0]                 tile_ack;
  logic [num_tiles-1:0][data_width-1:0] tile_dat;

  spmd_reset_seq reset_seq (
    .clk_i(clk_i), .reset_i(reset_i),
    .scrub_v_o(scrub_v), .scrub_addr_o(scrub_addr), .core_reset_o(core_reset)
  );

  spmd_loader loader (
    .clk_i(clk_i), .reset_i(core_reset), .start_i(start_i),
    .image_count_i(image_count_i), .image_idx_o(image_idx_o),
    .image_addr_i(image_addr_i), .image_data_i(image_data_i),
    .wb_cyc_o(wb_cyc), .wb_stb_o(wb_stb), .wb_we_o(wb_we), .wb_adr_o(wb_adr),
    .wb_dat_o(wb_dat_w), .wb_sel_o(), .wb_dat_i(wb_dat_r), .wb_ack_i(wb_ack),
    .print_stat_v_o(print_stat_v_o), .print_stat_id_o(print_stat_id_o),
    .print_stat_tag_o(print_stat_tag_o), .run_cycles_o(run_cycles_o),
    .loader_done_o(loader_done_o)
  );

  // counter runs off the outer reset so it spans the whole scrub
  spmd_wb_router router (
    .clk_i(clk_i), .reset_i(reset_i),
    .wb_cyc_i(wb_cyc), .wb_stb_i(wb_stb), .wb_we_i(wb_we), .wb_adr_i(wb_adr),
    .wb_dat_i(wb_dat_w), .wb_dat_o(wb_dat_r), .wb_ack_o(wb_ack),
    .tile_stb_o(tile_stb), .tile_dat_i(tile_dat), .tile_ack_i(tile_ack)
  );

  spmd_tile tile0 (
    .clk_i(clk_i), .reset_i(core_reset), .scrub_v_i(scrub_v), .scrub_addr_i(scrub_addr),
    .wb_stb_i(tile_stb[0]), .wb_we_i(wb_we), .wb_offset_i(wb_adr.tile.offset),
    .wb_dat_i(wb_dat_w), .wb_dat_o(tile_dat[0]), .wb_ack_o(tile_ack[0])
  );

  spmd_tile tile1 (
    .clk_i(clk_i), .reset_i(core_reset), .scrub_v_i(scrub_v), .scrub_addr_i(scrub_addr),
    .wb_stb_i(tile_stb[1]), .wb_we_i(wb_we), .wb_offset_i(wb_adr.tile.offset),
    .wb_dat_i(wb_dat_w), .wb_dat_o(tile_dat[1]), .wb_ack_o(tile_ack[1])
  );

  spmd_tile tile2 (
    .clk_i(clk_i), .reset_i(core_reset), .scrub_v_i(scrub_v), .scrub_addr_i(scrub_addr),
    .wb_stb_i(tile_stb[2]), .wb_we_i(wb_we), .wb_offset_i(wb_adr.tile.offset),
    .wb_dat_i(wb_dat_w), .wb_dat_o(tile_dat[2]), .wb_ack_o(tile_ack[2])
  );

  spmd_tile tile3 (
    .clk_i(clk_i), .reset_i(core_reset), .scrub_v_i(scrub_v), .scrub_addr_i(scrub_addr),
    .wb_stb_i(tile_stb[3]), .wb_we_i(wb_we), .wb_offset_i(wb_adr.tile.offset),
    .wb_dat_i(wb_dat_w), .wb_dat_o(tile_dat[3]), .wb_ack_o(tile_ack[3])
  );

endmodule

// File: hw/spmd_pkg.sv
// shared sizes, register offsets, loader state codes and the word address
// union for the spmd subsystem. rtl files pull names in with a wildcard
// import and use scoped names in port lists
package spmd_pkg;

  localparam int data_width      = 32;
  localparam int num_tiles       = 4;
  localparam int tile_id_width   = 2;
  localparam int dmem_words      = 64;
  localparam int dmem_addr_width = $clog2(dmem_words);
  localparam int offset_width    = 8;
  localparam int reset_depth     = 3;

  // tile registers sit right above the data memory
  localparam logic [offset_width-1:0] csr_len    = 8'd64;
  localparam logic [offset_width-1:0] csr_start  = 8'd65;
  localparam logic [offset_width-1:0] csr_status = 8'd66; // bit 0 is done
  localparam logic [offset_width-1:0] csr_result = 8'd67;

  localparam logic [7:0] host_csr_cycle   = 8'd0;
  localparam logic [7:0] host_csr_scratch = 8'd1;

  localparam logic [2:0] ld_idle   = 3'd0;
  localparam logic [2:0] ld_load   = 3'd1;
  localparam logic [2:0] ld_start  = 3'd2;
  localparam logic [2:0] ld_poll   = 3'd3;
  localparam logic [2:0] ld_result = 3'd4;
  localparam logic [2:0] ld_cycle  = 3'd5;

  typedef struct packed {
    logic                     host_sel;
    logic [20:0]              unused;
    logic [tile_id_width-1:0] tile_id;
    logic [offset_width-1:0]  offset;
  } spmd_tile_view_s;

  typedef struct packed {
    logic        host_sel;
    logic [22:0] unused;
    logic [7:0]  csr_id;
  } spmd_host_view_s;

  // host_sel picks which view applies
  typedef union packed {
    spmd_tile_view_s tile;
    spmd_host_view_s host;
  } spmd_epa_u;

endpackage

// File: hw/spmd_reset_seq.sv
// power-up sequencer. after reset every tile data memory word is cleared,
// one address per cycle, then core reset is held for a few more stages
// before the tiles and the loader are let go
`timescale 1ns/1ps

module spmd_reset_seq (
  input  logic                              clk_i,
  input  logic                              reset_i,
  output logic                              scrub_v_o,
  output logic [spmd_pkg::offset_width-1:0] scrub_addr_o,
  output logic                              core_reset_o
);
  import spmd_pkg::*;

  logic [offset_width-1:0] addr_r;
  logic                    busy_r;
  logic [reset_depth-1:0]  stage_r;

  // sweep counter
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      addr_r <= '0;
      busy_r <= 1'b1;
    end else if (busy_r) begin
      addr_r <= addr_r + 1'b1;
      if (addr_r == offset_width'(dmem_words - 1)) begin
        busy_r <= 1'b0; // last word written this cycle
      end
    end
  end

  // busy level ripples through the release chain
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      stage_r <= '1;
    end else begin
      stage_r <= {stage_r[reset_depth-2:0], busy_r};
    end
  end

  assign scrub_v_o    = busy_r;
  assign scrub_addr_o = addr_r;
  assign core_reset_o = stage_r[reset_depth-1];

endmodule

// File: hw/spmd_tile.sv
// compute tile: data memory, len/start/status/result registers and a
// summing engine that adds the first len words, one per cycle.
// sits behind the router as a wishbone classic slave with a registered ack
`timescale 1ns/1ps

module spmd_tile (
  input  logic                              clk_i,
  input  logic                              reset_i,
  input  logic                              scrub_v_i,
  input  logic [spmd_pkg::offset_width-1:0] scrub_addr_i,
  input  logic                              wb_stb_i,
  input  logic                              wb_we_i,
  input  logic [spmd_pkg::offset_width-1:0] wb_offset_i,
  input  logic [spmd_pkg::data_width-1:0]   wb_dat_i,
  output logic [spmd_pkg::data_width-1:0]   wb_dat_o,
  output logic                              wb_ack_o
);
  import spmd_pkg::*;

  logic [data_width-1:0]   mem_r [dmem_words];
  logic [data_width-1:0]   len_r;
  logic [data_width-1:0]   acc_r;
  logic [data_width-1:0]   rdata_r;
  logic [offset_width-1:0] idx_r;
  logic                    ack_r;
  logic                    run_r;
  logic                    done_r;
  logic                    fire;
  logic                    is_mem;
  logic                    bus_wr;

  assign fire   = wb_stb_i & ~ack_r; // new request this cycle
  assign is_mem = wb_offset_i < offset_width'(dmem_words);
  assign bus_wr = fire & wb_we_i;

  // single write port, scrub has priority
  always_ff @(posedge clk_i) begin
    if (scrub_v_i) begin
      mem_r[scrub_addr_i[dmem_addr_width-1:0]] <= '0;
    end else if (bus_wr && is_mem) begin
      mem_r[wb_offset_i[dmem_addr_width-1:0]] <= wb_dat_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ack_r  <= 1'b0;
      run_r  <= 1'b0;
      done_r <= 1'b0;
      len_r  <= '0;
      acc_r  <= '0;
      idx_r  <= '0;
    end else begin
      ack_r <= fire;
      if (bus_wr && wb_offset_i == csr_len) begin
        len_r <= wb_dat_i;
      end
      if (bus_wr && wb_offset_i == csr_start) begin
        run_r  <= 1'b1;
        done_r <= 1'b0;
        acc_r  <= '0;
        idx_r  <= '0;
      end else if (run_r) begin
        // one extra cycle to notice the end, so done lands len+1 after start
        if (data_width'(idx_r) == len_r) begin
          run_r  <= 1'b0;
          done_r <= 1'b1;
        end else begin
          acc_r <= acc_r + mem_r[idx_r[dmem_addr_width-1:0]];
          idx_r <= idx_r + 1'b1;
        end
      end
    end
  end

  // read data captured with the request, valid alongside ack
  always_ff @(posedge clk_i) begin
    if (fire) begin
      if (is_mem) begin
        rdata_r <= mem_r[wb_offset_i[dmem_addr_width-1:0]];
      end else begin
        case (wb_offset_i)
          csr_len:    rdata_r <= len_r;
          csr_status: rdata_r <= {{(data_width-1){1'b0}}, done_r};
          csr_result: rdata_r <= acc_r;
          default:    rdata_r <= '0;
        endcase
      end
    end
  end

  assign wb_dat_o = rdata_r;
  assign wb_ack_o = ack_r;

endmodule

// File: hw/spmd_wb_router.sv
// wishbone address router between the host loader and the tiles.
// tile addresses go to one tile strobe; host addresses and anything that
// decodes nowhere are answered here, including the free-running cycle counter
`timescale 1ns/1ps

module spmd_wb_router (
  input  logic                                                  clk_i,
  input  logic                                                  reset_i,
  input  logic                                                  wb_cyc_i,
  input  logic                                                  wb_stb_i,
  input  logic                                                  wb_we_i,
  input  spmd_pkg::spmd_epa_u                                   wb_adr_i,
  input  logic [spmd_pkg::data_width-1:0]                       wb_dat_i,
  output logic [spmd_pkg::data_width-1:0]                       wb_dat_o,
  output logic                                                  wb_ack_o,
  output logic [spmd_pkg::num_tiles-1:0]                        tile_stb_o,
  input  logic [spmd_pkg::num_tiles-1:0][spmd_pkg::data_width-1:0] tile_dat_i,
  input  logic [spmd_pkg::num_tiles-1:0]                        tile_ack_i
);
  import spmd_pkg::*;

  logic                  req;
  logic                  tile_hit;
  logic                  local_fire;
  logic                  local_ack_r;
  logic [data_width-1:0] cycle_r;
  logic [data_width-1:0] local_rdata_r;

  assign req = wb_cyc_i & wb_stb_i;
  // stray bits above the tile id mean no such tile
  assign tile_hit   = ~wb_adr_i.tile.host_sel && (wb_adr_i.tile.unused == '0);
  assign local_fire = req & ~tile_hit & ~local_ack_r;

  always_comb begin
    tile_stb_o = '0;
    if (req && tile_hit) begin
      tile_stb_o[wb_adr_i.tile.tile_id] = 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      cycle_r     <= '0;
      local_ack_r <= 1'b0;
    end else begin
      cycle_r     <= cycle_r + 1'b1;
      local_ack_r <= local_fire;
    end
  end

  always_ff @(posedge clk_i) begin
    if (local_fire) begin
      if (!wb_adr_i.host.host_sel) begin
        local_rdata_r <= '0; // unmapped tile address
      end else begin
        case (wb_adr_i.host.csr_id)
          host_csr_cycle: local_rdata_r <= cycle_r;
          default:        local_rdata_r <= '0;
        endcase
      end
    end
  end

  assign wb_ack_o = local_ack_r | (tile_hit & tile_ack_i[wb_adr_i.tile.tile_id]);
  assign wb_dat_o = tile_hit ? tile_dat_i[wb_adr_i.tile.tile_id] : local_rdata_r;

endmodule

// File: run_sim.sh
#!/bin/sh
# build and run the spmd testbench with Verilator, result taken from sim.log
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module spmd_testbench \
  -f spmd_manycore.f -o spmd_sim || exit 1
./obj_dir/spmd_sim > sim.log 2>&1 || echo "TESTBENCH FAILED" >> sim.log
cat sim.log
grep -q "TESTBENCH FAILED" sim.log && exit 1 || exit 0

// File: spmd_manycore.f
hw/spmd_pkg.sv
hw/spmd_reset_seq.sv
hw/spmd_tile.sv
hw/spmd_wb_router.sv
hw/spmd_loader.sv
hw/spmd_manycore.sv
tests/spmd_properties.sv
tests/spmd_testbench.sv

// File: tests/spmd_properties.sv
// concurrent checks on the host wishbone bus and on the power-up sequence
// of spmd_manycore, attached to the top level by the bind at the bottom
`timescale 1ns/1ps

module spmd_properties (
  input logic clk_i,
  input logic reset_i,
  input logic wb_stb_i,
  input logic wb_ack_i,
  input logic scrub_v_i,
  input logic core_reset_i,
  input logic print_stat_v_i
);
  import spmd_pkg::*;

  logic [3:0] since_scrub_r; // saturating

  always_ff @(posedge clk_i) begin
    if (reset_i || scrub_v_i) begin
      since_scrub_r <= '0;
    end else if (since_scrub_r != '1) begin
      since_scrub_r <= since_scrub_r + 1'b1;
    end
  end

  ack_needs_stb: assert property (@(posedge clk_i) disable iff (core_reset_i)
    wb_ack_i |-> wb_stb_i)
    else $error("bus ack seen while stb is low");

  stb_held: assert property (@(posedge clk_i) disable iff (core_reset_i)
    (wb_stb_i && !wb_ack_i) |=> wb_stb_i)
    else $error("stb dropped before ack");

  // release only after the full chain behind the scrub
  release_late: assert property (@(posedge clk_i) disable iff (reset_i)
    !core_reset_i |-> since_scrub_r >= 4'(reset_depth))
    else $error("core reset released too soon after the scrub");

  no_stat_in_reset: assert property (@(posedge clk_i) disable iff (reset_i)
    core_reset_i |-> !print_stat_v_i)
    else $error("print_stat raised while cores are in reset");

endmodule

bind spmd_manycore spmd_properties props0 (
  .clk_i(clk_i), .reset_i(reset_i), .wb_stb_i(wb_stb), .wb_ack_i(wb_ack),
  .scrub_v_i(scrub_v), .core_reset_i(core_reset), .print_stat_v_i(print_stat_v_o)
);

// File: tests/spmd_testbench.sv
// testbench for spmd_manycore. builds random program images from an lfsr,
// keeps a shadow model of every tile memory and len register, runs the
// loader a few times and checks each print_stat result and the cycle count
`timescale 1ns/1ps

module spmd_testbench;
  import spmd_pkg::*;

  localparam int num_runs      = 3;
  localparam int max_entries   = 256;
  localparam int clk_period    = 20;
  localparam int settle_cycles = dmem_words + reset_depth + 4; // scrub plus release
  localparam int run_budget    = settle_cycles + 4 * max_entries + num_tiles * dmem_words + 256;
  localparam int timeout_ns    = num_runs * run_budget * clk_period * 4;

  logic                     clk_i;
  logic                     reset_i;
  logic                     start_i;
  logic [7:0]               image_count_i;
  logic [7:0]               image_idx_o;
  spmd_epa_u                image_addr_i;
  logic [data_width-1:0]    image_data_i;
  logic                     print_stat_v_o;
  logic [tile_id_width-1:0] print_stat_id_o;
  logic [data_width-1:0]    print_stat_tag_o;
  logic [data_width-1:0]    run_cycles_o;
  logic                     loader_done_o;

  spmd_epa_u                img_addr [max_entries];
  logic [data_width-1:0]    img_data [max_entries];
  int                       img_count;
  logic [31:0]              lfsr_r;
  logic [data_width-1:0]    shadow_mem [num_tiles][dmem_words];
  logic [data_width-1:0]    shadow_len [num_tiles];
  logic [tile_id_width-1:0] stat_id_q [$];
  logic [data_width-1:0]    stat_tag_q [$];
  logic [data_width-1:0]    cycles_seen [num_runs];
  int                       done_count;
  int                       stat_at_done;
  logic                     started;
  logic                     stat_prev;
  logic                     done_prev;
  int                       tag_errors;
  int                       id_errors;
  int                       other_errors;

  spmd_manycore dut0 (
    .clk_i(clk_i), .reset_i(reset_i), .start_i(start_i),
    .image_count_i(image_count_i), .image_idx_o(image_idx_o),
    .image_addr_i(image_addr_i), .image_data_i(image_data_i),
    .print_stat_v_o(print_stat_v_o), .print_stat_id_o(print_stat_id_o),
    .print_stat_tag_o(print_stat_tag_o), .run_cycles_o(run_cycles_o),
    .loader_done_o(loader_done_o)
  );

  // same-cycle image lookup
  assign image_addr_i = img_addr[image_idx_o];
  assign image_data_i = img_data[image_idx_o];

  initial begin
    clk_i = 1'b0;
    forever #(clk_period / 2) clk_i = ~clk_i;
  end

  initial begin
    #(timeout_ns);
    $display("watchdog expired after %0d ns, the loader never finished", timeout_ns);
    $display("TESTBENCH FAILED");
    $finish;
  end

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_r = lfsr_step(lfsr_r);
      v = {v[30:0], lfsr_r[0]};
    end
    return v;
  endfunction

  function automatic spmd_epa_u make_tile_addr(input logic [tile_id_width-1:0] id,
                                               input logic [offset_width-1:0] off);
    spmd_epa_u a;
    a = '0;
    a.tile.tile_id = id;
    a.tile.offset  = off;
    return a;
  endfunction

  // append one image entry and apply it to the shadow model, last write wins
  task automatic add_entry(input spmd_epa_u a, input logic [data_width-1:0] d);
    img_addr[img_count] = a;
    img_data[img_count] = d;
    img_count++;
    if (!a.tile.host_sel && a.tile.unused == '0) begin
      if (a.tile.offset < offset_width'(dmem_words)) begin
        shadow_mem[a.tile.tile_id][a.tile.offset[dmem_addr_width-1:0]] = d;
      end else if (a.tile.offset == csr_len) begin
        shadow_len[a.tile.tile_id] = d;
      end
    end
  endtask

  task automatic build_image(input int run);
    int                      nwrites;
    logic [offset_width-1:0] off;
    logic [data_width-1:0]   len;
    spmd_epa_u               a;
    img_count = 0;
    for (int t = 0; t < num_tiles; t++) begin
      nwrites = int'(take_bits(5)) + int'(take_bits(4)); // sparse, many words stay old
      for (int w = 0; w < nwrites; w++) begin
        off = offset_width'(take_bits(dmem_addr_width));
        add_entry(make_tile_addr(tile_id_width'(t), off), take_bits(data_width));
      end
      if (run == 1 && t == 1) begin
        len = '0; // empty sum
      end else begin
        len = take_bits(dmem_addr_width) + 32'd1;
      end
      add_entry(make_tile_addr(tile_id_width'(t), csr_len), len);
    end
    // writes that decode nowhere, acked and dropped
    a = '0;
    a.host.host_sel = 1'b1;
    a.host.csr_id   = 8'h5a;
    add_entry(a, take_bits(data_width));
    a = make_tile_addr(2'd1, 8'd3);
    a.tile.unused[0] = 1'b1;
    add_entry(a, take_bits(data_width));
  endtask

  function automatic logic [data_width-1:0] expected_sum(input int t);
    logic [data_width-1:0] sum;
    sum = '0;
    for (int i = 0; i < dmem_words; i++) begin
      if (32'(i) < shadow_len[t]) sum = sum + shadow_mem[t][i];
    end
    return sum;
  endfunction

  task automatic compare_tag(input string name, input logic [data_width-1:0] exp,
                             input logic [data_width-1:0] act);
    if (act !== exp) begin
      tag_errors++;
      $display("Fail %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic compare_id(input string name, input logic [tile_id_width-1:0] exp,
                            input logic [tile_id_width-1:0] act);
    if (act !== exp) begin
      id_errors++;
      $display("Fail %s expected %0d actual %0d", name, exp, act);
    end
  endtask

  // outputs sampled mid-cycle
  always @(negedge clk_i) begin
    if (!reset_i && !started && (print_stat_v_o !== 1'b0 || loader_done_o !== 1'b0)) begin
      other_errors++;
      $display("loader output active before any start was given");
    end
    if (print_stat_v_o && stat_prev) begin
      other_errors++;
      $display("print_stat pulse lasted more than one cycle");
    end
    if (loader_done_o && done_prev) begin
      other_errors++;
      $display("loader_done pulse lasted more than one cycle");
    end
    if (print_stat_v_o === 1'b1) begin
      stat_id_q.push_back(print_stat_id_o);
      stat_tag_q.push_back(print_stat_tag_o);
    end
    if (loader_done_o === 1'b1) begin
      if (done_count < num_runs) cycles_seen[done_count] = run_cycles_o;
      stat_at_done = stat_id_q.size();
      done_count++;
    end
    stat_prev = print_stat_v_o;
    done_prev = loader_done_o;
  end

  task automatic run_program(input int run);
    stat_id_q.delete();
    stat_tag_q.delete();
    @(posedge clk_i);
    image_count_i <= 8'(img_count);
    start_i       <= 1'b1;
    started = 1'b1;
    @(posedge clk_i);
    start_i <= 1'b0;
    wait (done_count == run + 1);
    if (stat_at_done != num_tiles) begin
      other_errors++;
      $display("run %0d gave %0d print_stat pulses before done, not %0d",
               run, stat_at_done, num_tiles);
    end
    repeat (4) @(posedge clk_i); // nothing may follow the done pulse
    if (stat_id_q.size() != num_tiles || done_count != run + 1) begin
      other_errors++;
      $display("run %0d produced extra pulses after loader_done", run);
    end else begin
      for (int t = 0; t < num_tiles; t++) begin
        compare_id($sformatf("run%0d stat%0d id", run, t), tile_id_width'(t), stat_id_q[t]);
        compare_tag($sformatf("run%0d tile%0d sum", run, t), expected_sum(t), stat_tag_q[t]);
      end
    end
  endtask

  initial begin
    reset_i       <= 1'b1;
    start_i       <= 1'b0;
    image_count_i <= '0;
    lfsr_r       = 32'h5647_8fc3;
    started      = 1'b0;
    stat_prev    = 1'b0;
    done_prev    = 1'b0;
    done_count   = 0;
    stat_at_done = 0;
    tag_errors   = 0;
    id_errors    = 0;
    other_errors = 0;
    for (int i = 0; i < max_entries; i++) begin
      img_addr[i] = '0;
      img_data[i] = '0;
    end
    for (int t = 0; t < num_tiles; t++) begin
      shadow_len[t] = '0;
      for (int i = 0; i < dmem_words; i++) shadow_mem[t][i] = '0; // scrubbed state
    end
    repeat (4) @(posedge clk_i);
    reset_i <= 1'b0;
    repeat (settle_cycles) @(posedge clk_i);
    for (int run = 0; run < num_runs; run++) begin
      build_image(run);
      run_program(run);
    end
    if (cycles_seen[0] == '0) begin
      other_errors++;
      $display("cycle count of the first run is zero");
    end
    for (int r = 1; r < num_runs; r++) begin
      if (cycles_seen[r] <= cycles_seen[r-1]) begin
        other_errors++;
        $display("cycle count did not grow from run %0d to run %0d", r - 1, r);
      end
    end
    $display("errors: tag %0d, id %0d, other %0d", tag_errors, id_errors, other_errors);
    if (tag_errors + id_errors + other_errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule
